// File: Makefile
# verilator build and run of the z80 port block testbench

TOP := zports_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard source/*.sv) verification/zports_tb.sv
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)

# status comes from the search for the pass line
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "Done: no errors"

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: build.f
source/zport_addr_pkg.sv
source/zport_cfg_pkg.sv
source/zport_bus_if.sv
source/zport_strobe.sv
source/zport_decode.sv
source/zport_regs.sv
source/zport_readmux.sv
source/zports_top.sv
verification/zports_tb.sv

// File: source/zport_addr_pkg.sv
// port address bytes, decoded port-select type
// and the sub-index width shared by decode, regs and read mux

package zport_addr_pkg;

	////////////////////////////////////////////////////////////
	// low address bytes of the ports

	localparam logic [7:0] port_fe = 8'hFE; // keyboard, tape, border, beeper
	localparam logic [7:0] port_f6 = 8'hF6; // FE alias without beeper
	localparam logic [7:0] port_fd = 8'hFD; // 7FFD paging
	localparam logic [7:0] port_f7 = 8'hF7; // EFF7 paging
	localparam logic [7:0] port_1f = 8'h1F; // kempston joystick
	localparam logic [7:0] port_df = 8'hDF; // kempston mouse
	localparam logic [7:0] port_bf = 8'hBF; // config write
	localparam logic [7:0] port_be = 8'hBE; // config readback, nmi end

	// scratch bytes, shadow mode only
	localparam logic [7:0] port_2f = 8'h2F;
	localparam logic [7:0] port_4f = 8'h4F;
	localparam logic [7:0] port_6f = 8'h6F;
	localparam logic [7:0] port_8f = 8'h8F;

	////////////////////////////////////////////////////////////
	// decoded target

	typedef enum logic [3:0]
	{
		sel_none   = 4'd0,
		sel_fe     = 4'd1, // FE or F6
		sel_p7ffd  = 4'd2,
		sel_peff7  = 4'd3,
		sel_kjoy   = 4'd4,
		sel_kmouse = 4'd5,
		sel_bf     = 4'd6,
		sel_be     = 4'd7,
		sel_sav    = 4'd8
	} port_sel_t;

	// a[11:8] for BE, slot number for scratch ports
	localparam int sub_w = 4;

	// sub value marking FE (not F6), beeper is driven only then
	localparam logic [sub_w-1:0] sub_fe_beep = 4'h1;

endpackage

// File: source/zport_bus_if.sv
// decoded port access, decoder to register and read blocks

`timescale 1ns/1ps

interface zport_bus_if
	import zport_addr_pkg::*;
();

	logic             wr_stb; // one-cycle io write
	logic             rd_stb; // one-cycle io read
	port_sel_t        sel;    // which port
	logic [sub_w-1:0] sub;    // BE index or scratch slot
	logic             a3;     // inverted a[3], border bit 3
	logic [7:0]       din;    // z80 data

	// decoder drives the whole access
	modport decode
	(
		output wr_stb,
		output rd_stb,
		output sel,
		output sub,
		output a3,
		output din
	);

	modport regs
	(
		input wr_stb,
		input sel,
		input sub,
		input a3,
		input din
	);

	// read side only needs the target
	modport readmux
	(
		input sel,
		input sub
	);

endinterface

// File: source/zport_cfg_pkg.sv
// register field layouts, reset values,
// BF/BE bit positions

package zport_cfg_pkg;

	////////////////////////////////////////////////////////////
	// port BF layout, msb first

	typedef struct packed
	{
		logic [3:0] zero;      // always 0
		logic       set_nmi;   // bit 3
		logic       fntw_en;   // bit 2
		logic       romrw_en;  // bit 1
		logic       shadow_en; // bit 0
	} cfg_bf_t;

	localparam int bf_shadow_bit = 0;
	localparam int bf_romrw_bit  = 1;
	localparam int bf_fntw_bit   = 2;
	localparam int bf_nmi_bit    = 3;

	////////////////////////////////////////////////////////////
	// paging fields

	localparam int p7ffd_rom_bit    = 4; // rom select
	localparam int p7ffd_lock48_bit = 5; // 48k lock
	localparam int peff7_block1m_bit = 2; // 1 MB paging off
	localparam int peff7_ram0_bit    = 3; // ram page 0 in rom area

	// reset values, all clear
	localparam logic [7:0] p7ffd_rst  = 8'h00;
	localparam logic [7:0] peff7_rst  = 8'h00;
	localparam cfg_bf_t    cfg_rst    = cfg_bf_t'(8'h00);
	localparam logic [3:0] border_rst = 4'h0;
	localparam logic [7:0] sav_rst    = 8'h00;

	////////////////////////////////////////////////////////////
	// port BE readback

	localparam logic [3:0] be_sub_7ffd = 4'hA; // raw 7FFD
	localparam logic [3:0] be_sub_eff7 = 4'hB; // raw EFF7
	localparam logic [3:0] be_sub_dos  = 4'hC; // dos flag
	localparam int         be_dos_bit  = 0;

	localparam logic [7:0] be_none = 8'hFF; // nothing behind the index

endpackage

// File: source/zport_decode.sv
// port address decode with shadow gating, porthit,
// sel/sub generation

`timescale 1ns/1ps

module zport_decode
	import zport_addr_pkg::*;
(
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        wr_stb,
	input  logic        rd_stb,
	input  logic        shadow, // dos or shadow_en

	output logic        porthit,

	zport_bus_if.decode bus
);

	logic [7:0] loa; // low address byte

	assign loa = a[7:0];

	////////////////////////////////////////////////////////////
	// address match

	always_comb
	begin
		porthit = 1'b0;
		bus.sel = sel_none;
		bus.sub = '0;

		case (loa)
			port_fe, port_f6:
			begin
				porthit = 1'b1;
				bus.sel = sel_fe;
				if (loa == port_fe)
					bus.sub = sub_fe_beep; // beeper on FE only
			end
			port_fd:
			begin
				porthit = 1'b1;
				if (!a[15]) // 7FFD, not AY
					bus.sel = sel_p7ffd;
			end
			port_f7:
			begin
				if (a[8] && !shadow)
				begin
					porthit = 1'b1;
					if (!a[12]) // EFF7
						bus.sel = sel_peff7;
				end
			end
			port_1f:
			begin
				if (!shadow) // in shadow 1F is not the joystick
				begin
					porthit = 1'b1;
					bus.sel = sel_kjoy;
				end
			end
			port_df:
			begin
				porthit = 1'b1;
				bus.sel = sel_kmouse;
			end
			port_bf:
			begin
				porthit = 1'b1;
				bus.sel = sel_bf;
			end
			port_be:
			begin
				porthit = 1'b1;
				bus.sel = sel_be;
				bus.sub = sub_w'(a[11:8]); // readback index
			end
			port_2f, port_4f, port_6f, port_8f:
			begin
				if (shadow)
				begin
					porthit = 1'b1;
					bus.sel = sel_sav;
					bus.sub = sub_w'(loa[6:5]); // slot 0..3
				end
			end
			default:
			begin
				porthit = 1'b0;
			end
		endcase
	end

	// pass-through of the cycle itself
	assign bus.wr_stb = wr_stb;
	assign bus.rd_stb = rd_stb;
	assign bus.a3     = ~a[3];
	assign bus.din    = din;

endmodule

// File: source/zport_readmux.sv
// z80 read data multiplexer and data output enable

`timescale 1ns/1ps

module zport_readmux
	import zport_addr_pkg::*;
	import zport_cfg_pkg::*;
(
	zport_bus_if.readmux    bus,

	input  logic            iorq_n,
	input  logic            rd_n,
	input  logic            porthit,

	input  logic [4:0]      keys_in,   // keyboard columns
	input  logic            tape_read,
	input  logic [4:0]      kj_in,     // kempston joystick
	input  logic [7:0]      mus_in,    // kempston mouse
	input  logic [7:0]      p7ffd_raw,
	input  logic [7:0]      peff7_raw,
	input  cfg_bf_t         cfg,
	input  logic [3:0][7:0] sav_q,
	input  logic            dos,

	output logic [7:0]      dout,
	output logic            dataout
);

	logic [7:0] be_mux; // BE readback

	////////////////////////////////////////////////////////////
	// port BE index

	always_comb
	begin
		be_mux = be_none;
		case (bus.sub)
			be_sub_7ffd: be_mux = p7ffd_raw; // unmasked
			be_sub_eff7: be_mux = peff7_raw;
			be_sub_dos:
			begin
				be_mux = 8'h00;
				be_mux[be_dos_bit] = dos;
			end
			default:     be_mux = be_none;
		endcase
	end

	// byte to the z80
	always_comb
	begin
		case (bus.sel)
			sel_fe:     dout = {1'b1, tape_read, 1'b0, keys_in};
			sel_kjoy:   dout = {3'b000, kj_in};
			sel_kmouse: dout = mus_in;
			sel_bf:     dout = cfg;
			sel_be:     dout = be_mux;
			sel_sav:    dout = sav_q[bus.sub[1:0]];
			default:    dout = be_none; // idle bus reads FF
		endcase
	end

	// drive the data bus only on reads of our ports
	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

// File: source/zport_regs.sv
// config, paging, border and scratch registers
// with masked paging outputs and registered event strobes

`timescale 1ns/1ps

module zport_regs
	import zport_addr_pkg::*;
	import zport_cfg_pkg::*;
(
	input  logic            zclk,
	input  logic            rst_n,
	input  logic            dos,

	zport_bus_if.regs       bus,

	output logic            shadow,
	output logic [3:0]      border,
	output logic [7:0]      p7ffd_raw,
	output logic [7:0]      peff7_raw,
	output cfg_bf_t         cfg,
	output logic [3:0][7:0] sav_q,
	output logic [7:0]      p7ffd,
	output logic [7:0]      peff7,
	output logic [5:0]      pent1m_page,
	output logic            pent1m_rom,
	output logic            pent1m_1m_on,
	output logic            pent1m_ram0_0,
	output logic            romrw_en,
	output logic            fnt_en,
	output logic            set_nmi,
	output logic            clr_nmi,
	output logic            beeper_wr
);

	logic block1m;  // eff7 bit 2
	logic lock7ffd; // 48k lock in 1 MB-off mode

	assign block1m  = peff7_raw[peff7_block1m_bit];
	assign lock7ffd = p7ffd_raw[p7ffd_lock48_bit] & block1m;
	assign shadow   = dos | cfg.shadow_en;

	////////////////////////////////////////////////////////////
	// register writes

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_raw <= p7ffd_rst;
			peff7_raw <= peff7_rst;
			cfg       <= cfg_rst;
			border    <= border_rst;
			sav_q     <= {4{sav_rst}};
		end
		else if (bus.wr_stb)
		begin
			case (bus.sel)
				sel_p7ffd:
					if (!lock7ffd)
						p7ffd_raw <= bus.din;
				sel_peff7:
					peff7_raw <= bus.din;
				sel_bf:
				begin
					cfg.shadow_en <= bus.din[bf_shadow_bit];
					cfg.romrw_en  <= bus.din[bf_romrw_bit];
					cfg.fntw_en   <= bus.din[bf_fntw_bit];
					cfg.set_nmi   <= bus.din[bf_nmi_bit];
				end
				sel_fe:
					border <= {bus.a3, bus.din[2:0]}; // FE and F6
				sel_sav:
					sav_q[bus.sub[1:0]] <= bus.din;
				default:
					; // read-only ports hold nothing
			endcase
		end
	end

	// event strobes one edge after wr_stb
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			beeper_wr <= 1'b0;
			clr_nmi   <= 1'b0;
		end
		else
		begin
			beeper_wr <= bus.wr_stb && (bus.sel == sel_fe) && (bus.sub == sub_fe_beep);
			clr_nmi   <= bus.wr_stb && (bus.sel == sel_be);
		end
	end

	////////////////////////////////////////////////////////////
	// derived outputs

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[7:5]), p7ffd_raw[4:0]};
	assign peff7 = block1m ? {peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]}
	                       : peff7_raw;

	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]}; // full 1 MB page
	assign pent1m_rom    = p7ffd_raw[p7ffd_rom_bit];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_raw[peff7_ram0_bit];

	assign romrw_en = cfg.romrw_en;
	assign fnt_en   = cfg.fntw_en;
	assign set_nmi  = cfg.set_nmi;

endmodule

// File: source/zport_strobe.sv
// z80 iorq/rd/wr levels to single-cycle write and read strobes

`timescale 1ns/1ps

module zport_strobe
(
	input  logic zclk,
	input  logic rst_n,

	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,

	output logic wr_stb,
	output logic rd_stb
);

	logic io_wr; // io write level
	logic io_rd; // io read level
	logic io_wr_q; // previous sample
	logic io_rd_q;

	assign io_wr = ~(iorq_n | wr_n);
	assign io_rd = ~(iorq_n | rd_n);

	////////////////////////////////////////////////////////////
	// sample the bus levels

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_q <= 1'b0;
			io_rd_q <= 1'b0;
		end
		else
		begin
			io_wr_q <= io_wr;
			io_rd_q <= io_rd;
		end
	end

	// rising edge of the level -> one strobe per cycle
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
		end
		else
		begin
			wr_stb <= io_wr & ~io_wr_q; // long cycles give no second pulse
			rd_stb <= io_rd & ~io_rd_q;
		end
	end

endmodule

// File: source/zports_top.sv
// z80 i/o port block top, strobe + decode + regs + read mux

`timescale 1ns/1ps

module zports_top
	import zport_cfg_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,

	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,

	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,

	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic [3:0]  border,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        fnt_en,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic        beeper_wr
);

	logic            wr_stb;
	logic            rd_stb;
	logic            shadow;    // dos or BF bit 0
	logic [7:0]      p7ffd_raw;
	logic [7:0]      peff7_raw;
	cfg_bf_t         cfg;
	logic [3:0][7:0] sav_q;     // scratch bytes

	zport_bus_if bus ();

	////////////////////////////////////////////////////////////
	// blocks

	zport_strobe u_strobe
	(
		.zclk   (zclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.wr_stb (wr_stb),
		.rd_stb (rd_stb)
	);

	zport_decode u_decode
	(
		.a       (a),
		.din     (din),
		.wr_stb  (wr_stb),
		.rd_stb  (rd_stb),
		.shadow  (shadow),
		.porthit (porthit),
		.bus     (bus.decode)
	);

	zport_regs u_regs
	(
		.zclk          (zclk),
		.rst_n         (rst_n),
		.dos           (dos),
		.bus           (bus.regs),
		.shadow        (shadow),
		.border        (border),
		.p7ffd_raw     (p7ffd_raw),
		.peff7_raw     (peff7_raw),
		.cfg           (cfg),
		.sav_q         (sav_q),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.romrw_en      (romrw_en),
		.fnt_en        (fnt_en),
		.set_nmi       (set_nmi),
		.clr_nmi       (clr_nmi),
		.beeper_wr     (beeper_wr)
	);

	zport_readmux u_readmux
	(
		.bus       (bus.readmux),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.porthit   (porthit),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.p7ffd_raw (p7ffd_raw),
		.peff7_raw (peff7_raw),
		.cfg       (cfg),
		.sav_q     (sav_q),
		.dos       (dos),
		.dout      (dout),
		.dataout   (dataout)
	);

endmodule

// File: verification/zports_stimulus.txt
# op addr data  rd hit  border p7ffd peff7 page flags pulses   (W write, R read, S inputs)
# S addr = {dos,00,kj,00,tape,keys} data = mouse; flags = {1m_on,nmi,fnt,romrw}; pulses = {beep,clr}
# reset state
R 0000 00  FF 0  0 00 00 00 8 00
R 00BF 00  00 1  0 00 00 00 8 00
# keys 15, tape 1, joystick 0A, mouse 5A, dos 0
S 0A35 5A  00 0  0 00 00 00 8 00
# port FE / F6
R 00FE 00  D5 1  0 00 00 00 8 00
W 00FE 05  00 1  5 00 00 00 8 10
W 00F6 03  00 1  B 00 00 00 8 00
R 00F6 00  D5 1  B 00 00 00 8 00
# paging and locks
W 7FFD 83  00 1  B 83 00 23 8 00
W EFF7 F5  00 1  B 03 B1 23 0 00
W 7FFD 34  00 1  B 14 B1 0C 0 00
W 7FFD 07  00 1  B 14 B1 0C 0 00
# BE readback
R 0ABE 00  34 1  B 14 B1 0C 0 00
R 0BBE 00  F5 1  B 14 B1 0C 0 00
R 05BE 00  FF 1  B 14 B1 0C 0 00
R 0CBE 00  00 1  B 14 B1 0C 0 00
# config, shadow off
W 00BF 0E  00 1  B 14 B1 0C 7 00
R 00BF 00  0E 1  B 14 B1 0C 7 00
R 002F 00  FF 0  B 14 B1 0C 7 00
R 001F 00  0A 1  B 14 B1 0C 7 00
R 00DF 00  5A 1  B 14 B1 0C 7 00
R EFF7 00  FF 1  B 14 B1 0C 7 00
# shadow on by BF bit 0
W 00BF 0F  00 1  B 14 B1 0C 7 00
W 002F C3  00 1  B 14 B1 0C 7 00
W 004F 3C  00 1  B 14 B1 0C 7 00
R 002F 00  C3 1  B 14 B1 0C 7 00
R 004F 00  3C 1  B 14 B1 0C 7 00
R 001F 00  FF 0  B 14 B1 0C 7 00
R EFF7 00  FF 0  B 14 B1 0C 7 00
W 00BE 00  00 1  B 14 B1 0C 7 01
R 00BF 00  0F 1  B 14 B1 0C 7 00
W 00BF 00  00 1  B 14 B1 0C 0 00
R 002F 00  FF 0  B 14 B1 0C 0 00
# shadow by dos
S 8A35 5A  00 0  B 14 B1 0C 0 00
R 002F 00  C3 1  B 14 B1 0C 0 00
R 0CBE 00  01 1  B 14 B1 0C 0 00
S 0A35 5A  00 0  B 14 B1 0C 0 00
R 002F 00  FF 0  B 14 B1 0C 0 00

// File: verification/zports_tb.sv
// z80 i/o port block testbench
// accesses and expected values come from the stimulus file

`timescale 1ns/1ps

module zports_tb;

	// one stimulus line
	typedef struct packed
	{
		logic [7:0]  op;     // W, R or S
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  rd;     // expected dout on reads
		logic        hit;    // expected porthit
		logic [3:0]  border;
		logic [7:0]  p7ffd;
		logic [7:0]  peff7;
		logic [5:0]  page;
		logic [3:0]  flags;  // {1m_on, set_nmi, fnt_en, romrw_en}
		logic [7:0]  pulses; // {beeper count, clr_nmi count}
	} rec_t;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;

	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [3:0]  border;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic        romrw_en;
	logic        fnt_en;
	logic        set_nmi;
	logic        clr_nmi;
	logic        beeper_wr;

	rec_t        recs[$];
	rec_t        cur;
	int          rec_idx = 0;
	int          limit = 0;    // cycle limit set after the file is read
	int          cyc_cnt = 0;
	int          beep_total = 0;
	int          nmi_total = 0;
	int          beep0;
	int          nmi0;
	logic [7:0]  eff7_last = 8'h00; // last byte taken by EFF7
	logic        got_hit;      // sampled mid-cycle
	logic [7:0]  got_dout;
	logic        got_dataout;

	zports_top dut0
	(
		.zclk          (zclk),
		.rst_n         (rst_n),
		.a             (a),
		.din           (din),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.dos           (dos),
		.keys_in       (keys_in),
		.tape_read     (tape_read),
		.kj_in         (kj_in),
		.mus_in        (mus_in),
		.dout          (dout),
		.dataout       (dataout),
		.porthit       (porthit),
		.border        (border),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.romrw_en      (romrw_en),
		.fnt_en        (fnt_en),
		.set_nmi       (set_nmi),
		.clr_nmi       (clr_nmi),
		.beeper_wr     (beeper_wr)
	);

	////////////////////////////////////////////////////////////
	// clock, pulse counters, timeout

	initial
	begin
		zclk = 1'b0;
		forever #50 zclk = ~zclk; // 100 ns period
	end

	always @(posedge zclk)
	begin
		if (beeper_wr)
			beep_total <= beep_total + 1; // one count per high cycle
		if (clr_nmi)
			nmi_total <= nmi_total + 1;
	end

	always @(posedge zclk)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (limit > 0 && cyc_cnt > limit)
			fail_stop($sformatf("timeout, run still going after %0d cycles", cyc_cnt));
	end

	////////////////////////////////////////////////////////////
	// helpers

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			fail_stop($sformatf("ERR %s got %h expected %h in record %0d",
				name, got, exp, rec_idx));
	endtask

	// inputs change 5 ns after the edge
	task automatic step();
		@(posedge zclk);
		#5;
	endtask

	// bus held 3 cycles then idle for 2
	task automatic bus_cycle(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		a = addr;
		din = data;
		iorq_n = 1'b0;
		wr_n = ~wr;
		rd_n = wr;
		step();
		step();
		@(negedge zclk); // strobe and write done with the bus steady
		got_hit = porthit;
		got_dout = dout;
		got_dataout = dataout;
		step();
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		step();
		step();
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(1'b1, addr, data);
	endtask

	task automatic io_read(input logic [15:0] addr);
		bus_cycle(1'b0, addr, 8'h00);
	endtask

	// addr packs {dos, 00, kj, 00, tape, keys} and data is the mouse byte
	task automatic set_static(input logic [15:0] v, input logic [7:0] m);
		keys_in = v[4:0];
		tape_read = v[5];
		kj_in = v[12:8];
		dos = v[15];
		mus_in = m;
		step();
	endtask

	task automatic load_stimulus();
		int          fd;
		int          n;
		int          cnt;
		logic [8*160-1:0] line;
		logic [7:0]  op;
		logic [15:0] f_addr;
		logic [15:0] f_data;
		logic [15:0] f_rd;
		logic [15:0] f_hit;
		logic [15:0] f_border;
		logic [15:0] f_p7ffd;
		logic [15:0] f_peff7;
		logic [15:0] f_page;
		logic [15:0] f_flags;
		logic [15:0] f_pulses;
		rec_t        rec;
		fd = $fopen("verification/zports_stimulus.txt", "r");
		if (fd == 0)
			fail_stop("cannot open the stimulus file");
		else
		begin
			while (!$feof(fd))
			begin
				line = '0;
				op = 8'h00;
				n = $fgets(line, fd);
				cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", op, f_addr,
					f_data, f_rd, f_hit, f_border, f_p7ffd, f_peff7, f_page,
					f_flags, f_pulses);
				if (n == 0 || cnt <= 0 || op == "#" || op == 8'h00)
					continue; // comment or blank line
				if (cnt != 11)
					fail_stop("malformed line in the stimulus file");
				rec.op = op;
				rec.addr = f_addr;
				rec.data = f_data[7:0];
				rec.rd = f_rd[7:0];
				rec.hit = f_hit[0];
				rec.border = f_border[3:0];
				rec.p7ffd = f_p7ffd[7:0];
				rec.peff7 = f_peff7[7:0];
				rec.page = f_page[5:0];
				rec.flags = f_flags[3:0];
				rec.pulses = f_pulses[7:0];
				recs.push_back(rec);
			end
			$fclose(fd);
		end
	endtask

	task automatic run_record();
		beep0 = beep_total;
		nmi0 = nmi_total;
		case (cur.op)
			"W":
			begin
				io_write(cur.addr, cur.data);
				check("porthit", 16'(got_hit), 16'(cur.hit));
				check("dataout", 16'(got_dataout), 16'h0000); // never on writes
				// a hit on xxF7 with a8 set and a12 clear is EFF7
				if (cur.hit && cur.addr[7:0] == 8'hF7 && cur.addr[8] && !cur.addr[12])
					eff7_last = cur.data;
			end
			"R":
			begin
				io_read(cur.addr);
				check("dout", 16'(got_dout), 16'(cur.rd));
				check("porthit", 16'(got_hit), 16'(cur.hit));
				check("dataout", 16'(got_dataout), 16'(cur.hit));
			end
			"S":
				set_static(cur.addr, cur.data);
			default:
				fail_stop("unknown operation in the stimulus file");
		endcase
		// state after the cycle
		check("border", 16'(border), 16'(cur.border));
		check("p7ffd", 16'(p7ffd), 16'(cur.p7ffd));
		check("peff7", 16'(peff7), 16'(cur.peff7));
		check("pent1m_page", 16'(pent1m_page), 16'(cur.page));
		check("pent1m_rom", 16'(pent1m_rom), 16'(cur.p7ffd[4])); // rom bit never masked
		check("pent1m_ram0_0", 16'(pent1m_ram0_0), 16'(eff7_last[3]));
		check("flags", 16'({pent1m_1m_on, set_nmi, fnt_en, romrw_en}), 16'(cur.flags));
		check("pulses", 16'({4'(beep_total - beep0), 4'(nmi_total - nmi0)}),
			16'(cur.pulses));
	endtask

	////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		rst_n = 1'b0;
		a = 16'h0000;
		din = 8'h00;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dos = 1'b0;
		keys_in = 5'h00;
		tape_read = 1'b0;
		kj_in = 5'h00;
		mus_in = 8'h00;
		load_stimulus();
		if (recs.size() == 0)
			fail_stop("stimulus file holds no records");
		limit = recs.size() * 5 + 50; // 5 cycles per access
		repeat (8) @(posedge zclk);
		#5;
		rst_n = 1'b1;
		step();
		for (int i = 0; i < recs.size(); i++)
		begin
			rec_idx = i;
			cur = recs[i];
			run_record();
		end
		$display("Done: no errors");
		$finish;
	end

endmodule
